// File: design/sifh_params.svh
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// timestamp width from the TDC
`define NP 12

// bin index width, top NB bits give the coarse bin
`define NB 6

// histogram count width, counts stop at all ones
`define PEAK_MAX 8

// bins per histogram
`define BIN_NUM 64

// samples taken in each build phase
`define SAMPLES_PER_HIS 300

`endif

// File: design/sifhPkg.sv
`default_nettype none

package sifhPkg;

`include "sifh_params.svh"

    // frame phases, in the order they run
    typedef enum logic [2:0] {
        CLEAR1, // zero the RAM
        BUILD1, // coarse histogram
        FIND1,  // coarse peak
        FILTER, // TH- / TH+ from coarse peak
        CLEAR2,
        BUILD2, // fine histogram inside the window
        FIND2,
        REPORT  // result pulse
    } sifhState_t;

    typedef logic [`NB-1:0] bin_t;

    typedef logic [`PEAK_MAX-1:0] count_t;

endpackage

`default_nettype wire

// File: design/histRam.sv
`timescale 1ns/100ps
`default_nettype none

`include "sifh_params.svh"

module histRam (
    input  wire                    clk,
    input  wire sifhPkg::bin_t     raddr,
    input  wire                    rEnable,
    input  wire sifhPkg::bin_t     waddr,
    input  wire                    wEnable,
    input  wire sifhPkg::count_t   wdata,
    output sifhPkg::count_t        rdata
);

    sifhPkg::count_t mem [0:`BIN_NUM-1];

    // write port
    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, same-address write in the same cycle gives the old count
    always_ff @(posedge clk) begin
        if (rEnable) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// File: design/hisBuilderFSM.sv
`timescale 1ns/100ps
`default_nettype none

module hisBuilderFSM (
    input  wire                    clk,
    input  wire                    res,
    input  wire                    smpValid,
    input  wire sifhPkg::bin_t     smpBin,
    input  wire                    builderFlush,
    input  wire sifhPkg::count_t   rdata,
    output sifhPkg::bin_t          raddr,
    output logic                   rEnable,
    output sifhPkg::bin_t          waddr,
    output logic                   wEnable,
    output sifhPkg::count_t        wdata,
    output logic                   hisBuildDone
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } bldState_t;

    bldState_t state;

    logic s1Valid;              // stage 2 holds a sample
    sifhPkg::bin_t s1Bin;

    logic fwdValid;             // last cycle's write for back-to-back hits
    sifhPkg::bin_t fwdBin;
    sifhPkg::count_t fwdVal;

    sifhPkg::count_t srcCount;
    sifhPkg::count_t incCount;

    // stage 1 reads the bin as the sample arrives
    assign raddr   = smpBin;
    assign rEnable = smpValid;

    // stage 2 uses the last write on a same-bin hit since the RAM read is stale
    assign srcCount = (fwdValid && fwdBin == s1Bin) ? fwdVal : rdata;
    assign incCount = (&srcCount) ? srcCount : srcCount + 1'b1; // saturate

    assign waddr   = s1Bin;
    assign wEnable = s1Valid;
    assign wdata   = incCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid  <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            s1Valid  <= smpValid;
            fwdValid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin  <= smpBin;
        fwdBin <= s1Bin;
        fwdVal <= incCount;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state        <= IDLE;
            hisBuildDone <= 1'b0;
        end else begin
            hisBuildDone <= 1'b0;
            case (state)
                IDLE: begin
                    if (builderFlush) begin
                        state <= DRAIN; // window may have caught nothing
                    end else if (smpValid) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (builderFlush) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (!smpValid && !s1Valid) begin
                        hisBuildDone <= 1'b1; // last write is in the RAM
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // two writes in a row to one bin must not lose the first increment
    assert property (@(posedge clk) disable iff (!res)
        (wEnable && $past(wEnable) && waddr == $past(waddr))
            |-> (wdata > $past(wdata)) || (&$past(wdata)));

endmodule

`default_nettype wire

// File: design/peakFinder.sv
`timescale 1ns/100ps
`default_nettype none

`include "sifh_params.svh"

module peakFinder (
    input  wire                    clk,
    input  wire                    res,
    input  wire                    findStart,
    input  wire sifhPkg::count_t   rdata,
    output sifhPkg::bin_t          raddr,
    output logic                   rEnable,
    output sifhPkg::bin_t          peakBin,
    output sifhPkg::count_t        peakVal,
    output logic                   findPeakFinish
);

    localparam sifhPkg::bin_t LAST_BIN = sifhPkg::bin_t'(`BIN_NUM - 1);

    logic cmpValid;             // rdata holds the count of cmpBin
    logic cmpLast;
    sifhPkg::bin_t cmpBin;

    // address sweep
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rEnable        <= 1'b0;
            raddr          <= '0;
            cmpValid       <= 1'b0;
            cmpLast        <= 1'b0;
            findPeakFinish <= 1'b0;
        end else begin
            if (findStart) begin
                rEnable <= 1'b1;
                raddr   <= '0;
            end else if (rEnable) begin
                rEnable <= (raddr != LAST_BIN);
                raddr   <= raddr + 1'b1;
            end
            cmpValid       <= rEnable;
            cmpLast        <= rEnable && (raddr == LAST_BIN);
            findPeakFinish <= cmpLast; // 2 cycles after the last read
        end
    end

    always_ff @(posedge clk) begin
        cmpBin <= raddr;
    end

    // running maximum, strict compare keeps the lower bin on a tie
    always_ff @(posedge clk) begin
        if (cmpValid) begin
            if (cmpBin == '0 || rdata > peakVal) begin
                peakVal <= rdata;
                peakBin <= cmpBin;
            end
        end
    end

    // sequencer must wait for the finish pulse before the next sweep
    assert property (@(posedge clk) disable iff (!res)
        findStart |-> !(rEnable || cmpValid || findPeakFinish));

endmodule

`default_nettype wire

// File: design/SiFHtop.sv
`timescale 1ns/100ps
`default_nettype none

`include "sifh_params.svh"

module SiFHtop (
    input  wire                    clk,
    input  wire                    res,
    input  wire [`NP-1:0]          data,
    input  wire                    dataValid,
    output logic                   wrEn,
    output sifhPkg::bin_t          coarsePeak,
    output sifhPkg::bin_t          finePeak,
    output sifhPkg::count_t        peakCount,
    output logic                   resultValid
);

    localparam int CNT_W = $clog2(`SAMPLES_PER_HIS + 1);
    localparam logic [CNT_W-1:0] SMP_TOTAL = CNT_W'(`SAMPLES_PER_HIS);
    localparam sifhPkg::bin_t LAST_BIN = sifhPkg::bin_t'(`BIN_NUM - 1);

    sifhPkg::sifhState_t state;
    sifhPkg::sifhState_t nextState;

    sifhPkg::bin_t clrAddr;
    logic [CNT_W-1:0] smpCnt;
    logic [`NP-1:0] thLow;      // TH-
    logic [`NP-1:0] thHigh;     // TH+

    logic clearing;
    logic building;
    logic accept;
    logic inWindow;

    logic smpValid;
    sifhPkg::bin_t smpBin;
    logic builderFlush;
    logic findStart;

    // builder side
    sifhPkg::bin_t bldRaddr;
    logic bldREnable;
    sifhPkg::bin_t bldWaddr;
    logic bldWEnable;
    sifhPkg::count_t bldWdata;
    logic hisBuildDone;

    // finder side
    sifhPkg::bin_t pfRaddr;
    logic pfREnable;
    sifhPkg::bin_t pfPeakBin;
    sifhPkg::count_t pfPeakVal;
    logic findPeakFinish;

    // RAM ports after the mux
    sifhPkg::bin_t ramRaddr;
    logic ramREnable;
    sifhPkg::bin_t ramWaddr;
    logic ramWEnable;
    sifhPkg::count_t ramWdata;
    sifhPkg::count_t ramRdata;

    assign clearing = (state == sifhPkg::CLEAR1) || (state == sifhPkg::CLEAR2);
    assign building = (state == sifhPkg::BUILD1) || (state == sifhPkg::BUILD2);

    assign wrEn   = building && (smpCnt != SMP_TOTAL);
    assign accept = wrEn && dataValid;

    // same as coarse bin == coarse peak
    assign inWindow = (data >= thLow) && (data <= thHigh);

    always_comb begin
        nextState = state;
        case (state)
            sifhPkg::CLEAR1: if (clrAddr == LAST_BIN) nextState = sifhPkg::BUILD1;
            sifhPkg::BUILD1: if (hisBuildDone) nextState = sifhPkg::FIND1;
            sifhPkg::FIND1:  if (findPeakFinish) nextState = sifhPkg::FILTER;
            sifhPkg::FILTER: nextState = sifhPkg::CLEAR2;
            sifhPkg::CLEAR2: if (clrAddr == LAST_BIN) nextState = sifhPkg::BUILD2;
            sifhPkg::BUILD2: if (hisBuildDone) nextState = sifhPkg::FIND2;
            sifhPkg::FIND2:  if (findPeakFinish) nextState = sifhPkg::REPORT;
            sifhPkg::REPORT: nextState = sifhPkg::CLEAR1;
            default:         nextState = sifhPkg::CLEAR1;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state        <= sifhPkg::CLEAR1;
            clrAddr      <= '0;
            smpCnt       <= '0;
            smpValid     <= 1'b0;
            builderFlush <= 1'b0;
            findStart    <= 1'b0;
            resultValid  <= 1'b0;
        end else begin
            state        <= nextState;
            clrAddr      <= clearing ? clrAddr + 1'b1 : '0; // wraps to 0 after the last bin
            smpValid     <= accept && ((state == sifhPkg::BUILD1) || inWindow);
            builderFlush <= accept && (smpCnt == SMP_TOTAL - 1'b1);
            findStart    <= building && hisBuildDone;
            resultValid  <= (state == sifhPkg::FIND2) && findPeakFinish;
            if (!building) begin
                smpCnt <= '0;
            end else if (accept) begin
                smpCnt <= smpCnt + 1'b1; // outside-window samples count too
            end
        end
    end

    always_ff @(posedge clk) begin
        // coarse bin in BUILD1, fine bin in BUILD2
        smpBin <= (state == sifhPkg::BUILD1) ? data[`NP-1 -: `NB] : data[`NP-`NB-1:0];
        if (state == sifhPkg::FILTER) begin
            thLow  <= {pfPeakBin, {(`NP - `NB){1'b0}}};
            thHigh <= {pfPeakBin, {(`NP - `NB){1'b1}}};
        end
        if ((state == sifhPkg::FIND2) && findPeakFinish) begin
            coarsePeak <= thLow[`NP-1 -: `NB];
            finePeak   <= pfPeakBin;
            peakCount  <= pfPeakVal;
        end
    end

    // RAM port owner follows the phase
    always_comb begin
        ramRaddr   = '0;
        ramREnable = 1'b0;
        ramWaddr   = '0;
        ramWEnable = 1'b0;
        ramWdata   = '0;
        if (clearing) begin
            ramWaddr   = clrAddr;
            ramWEnable = 1'b1; // writes zero
        end else if (building) begin
            ramRaddr   = bldRaddr;
            ramREnable = bldREnable;
            ramWaddr   = bldWaddr;
            ramWEnable = bldWEnable;
            ramWdata   = bldWdata;
        end else if ((state == sifhPkg::FIND1) || (state == sifhPkg::FIND2)) begin
            ramRaddr   = pfRaddr;
            ramREnable = pfREnable;
        end
    end

    histRam histRam_i (
        .clk     (clk),
        .raddr   (ramRaddr),
        .rEnable (ramREnable),
        .waddr   (ramWaddr),
        .wEnable (ramWEnable),
        .wdata   (ramWdata),
        .rdata   (ramRdata)
    );

    hisBuilderFSM hisBuilderFSM_i (
        .clk          (clk),
        .res          (res),
        .smpValid     (smpValid),
        .smpBin       (smpBin),
        .builderFlush (builderFlush),
        .rdata        (ramRdata),
        .raddr        (bldRaddr),
        .rEnable      (bldREnable),
        .waddr        (bldWaddr),
        .wEnable      (bldWEnable),
        .wdata        (bldWdata),
        .hisBuildDone (hisBuildDone)
    );

    peakFinder peakFinder_i (
        .clk            (clk),
        .res            (res),
        .findStart      (findStart),
        .rdata          (ramRdata),
        .raddr          (pfRaddr),
        .rEnable        (pfREnable),
        .peakBin        (pfPeakBin),
        .peakVal        (pfPeakVal),
        .findPeakFinish (findPeakFinish)
    );

    // clear and builder never drive the write port together
    assert property (@(posedge clk) disable iff (!res)
        $onehot0({clearing, bldWEnable}));

    assert property (@(posedge clk) disable iff (!res)
        resultValid |=> !resultValid);

endmodule

`default_nettype wire

// File: sim/sifhTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "sifh_params.svh"

module sifhTb;

    localparam int SMP = `SAMPLES_PER_HIS;
    localparam int FRAME_SMP = 2 * SMP;
    localparam int CNT_MAX = (1 << `PEAK_MAX) - 1;
    localparam int NUM_TESTS = 6;
    // two clears, two builds at half rate, two sweeps, FILTER and REPORT
    localparam int FRAME_CYCLES = 2 * `BIN_NUM + 2 * (FRAME_SMP + 3) + 2 * (`BIN_NUM + 2) + 2;
    localparam longint WATCHDOG_NS = 4 * FRAME_CYCLES * NUM_TESTS * 20;

    logic clk, res, dataValid, wrEn, resultValid;
    logic [`NP-1:0] data;
    sifhPkg::bin_t coarsePeak, finePeak;
    sifhPkg::count_t peakCount;

    logic [`NP-1:0] stim [0:FRAME_SMP-1];      // timestamps of the running test, offer order
    logic [`NP-1:0] savedStim [0:FRAME_SMP-1];
    integer seed;
    int framesSeen = 0;
    int testNum = 1;
    int testErr = 0;
    int errCnt = 0;
    int testsOk = 0;

    SiFHtop SiFHtop_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // first half gives the coarse histogram, second half the fine one
    function automatic void refPeaks(output sifhPkg::bin_t expCoarse,
                                     output sifhPkg::bin_t expFine,
                                     output sifhPkg::count_t expCount);
        int hist [0:`BIN_NUM-1];
        int pass;
        int best;
        int b;
        int i;
        for (pass = 0; pass < 2; pass++) begin
            hist = '{default: 0};
            for (i = pass * SMP; i < (pass + 1) * SMP; i++) begin
                if (pass == 0) begin
                    b = int'(stim[i][`NP-1 -: `NB]);
                end else if (stim[i][`NP-1 -: `NB] == expCoarse) begin
                    b = int'(stim[i][`NP-`NB-1:0]); // inside TH- .. TH+
                end else begin
                    b = -1;
                end
                if (b >= 0 && hist[b] < CNT_MAX) begin
                    hist[b]++;
                end
            end
            best = 0;
            for (b = 1; b < `BIN_NUM; b++) begin
                if (hist[b] > hist[best]) begin
                    best = b;   // lowest bin keeps a tie
                end
            end
            if (pass == 0) begin
                expCoarse = sifhPkg::bin_t'(best);
            end else begin
                expFine  = sifhPkg::bin_t'(best);
                expCount = sifhPkg::count_t'(hist[best]);
            end
        end
    endfunction

    task automatic checkBin(string name, sifhPkg::bin_t expVal, sifhPkg::bin_t actVal);
        if (actVal !== expVal) begin
            $display("** Error %s: expected %h, got %h", name, expVal, actVal);
            testErr++;
        end
    endtask

    task automatic checkCount(string name, sifhPkg::count_t expVal, sifhPkg::count_t actVal);
        if (actVal !== expVal) begin
            $display("** Error %s: expected %h, got %h", name, expVal, actVal);
            testErr++;
        end
    endtask

    task automatic checkFlag(string name, logic expVal, logic actVal);
        if (actVal !== expVal) begin
            $display("** Error %s: expected %h, got %h", name, expVal, actVal);
            testErr++;
        end
    endtask

    // kind 0 cluster, 1 busy bin outside the window, 2 tie, 3 one timestamp
    task automatic fillStim(int kind);
        logic [31:0] rnd;
        sifhPkg::bin_t peakC;
        sifhPkg::bin_t peakF;
        int i;
        rnd = $random(seed);
        peakC = rnd[`NB-1:0];
        peakF = rnd[`NB+7:8];
        for (i = 0; i < FRAME_SMP; i++) begin
            rnd = $random(seed);
            stim[i] = {peakC, rnd[`NP-`NB+15:16]};  // scatter inside the coarse window
            case (kind)
                0: begin
                    if (rnd[3:0] >= 4'd13) begin
                        stim[i] = rnd[31:32-`NP];     // stray photon
                    end else if (i >= SMP && rnd[3:0] < 4'd8) begin
                        stim[i] = {peakC, peakF};
                    end
                end
                1: begin
                    if (i < SMP && i % 3 == 0) begin
                        stim[i] = rnd[31:32-`NP];
                    end else if (i >= SMP && i % 2 == 0) begin
                        stim[i] = {sifhPkg::bin_t'(peakC + 1), peakF};
                    end else if (i >= SMP && i % 6 == 1) begin
                        stim[i] = {peakC, sifhPkg::bin_t'(peakF + 1)};
                    end
                end
                2: begin
                    if (i < SMP) begin
                        stim[i] = {sifhPkg::bin_t'((i % 2 == 1) ? 40 : 17), rnd[21:16]};
                    end else begin
                        stim[i] = {sifhPkg::bin_t'(17), sifhPkg::bin_t'((i % 2 == 1) ? 50 : 3)};
                    end
                end
                3: stim[i] = {sifhPkg::bin_t'(42), sifhPkg::bin_t'(60)};
            endcase
        end
    endtask

    // holds each timestamp until the DUT takes it
    task automatic offerSamples(int first, int last, bit gaps);
        logic [31:0] rnd;
        logic took;
        int i;
        i = first;
        while (i < last) begin
            data = stim[i];
            dataValid = 1'b1;
            if (gaps) begin
                rnd = $random(seed);
                dataValid = rnd[0];
            end
            @(negedge clk);
            took = wrEn && dataValid;
            @(posedge clk);
            #2;
            if (took) begin
                i++;
            end
        end
        dataValid = 1'b0;
    endtask

    task automatic runFrame(string name, bit gaps);
        int target;
        target = framesSeen + 1;
        offerSamples(0, FRAME_SMP, gaps);
        while (framesSeen < target) begin
            @(posedge clk);
        end
        #2;
        $display("test %0d %s: %s (coarse %h fine %h count %h)", testNum, name,
                 (testErr == 0) ? "ok" : "mismatch", coarsePeak, finePeak, peakCount);
        if (testErr == 0) begin
            testsOk++;
        end
        errCnt += testErr;
        testErr = 0;
        testNum++;
    endtask

    initial begin : compareResults
        sifhPkg::bin_t expCoarse;
        sifhPkg::bin_t expFine;
        sifhPkg::count_t expCount;
        forever begin
            @(negedge clk);
            if (res === 1'b1 && resultValid === 1'b1) begin
                refPeaks(expCoarse, expFine, expCount);
                checkBin("coarsePeak", expCoarse, coarsePeak);
                checkBin("finePeak", expFine, finePeak);
                checkCount("peakCount", expCount, peakCount);
                framesSeen++;
            end
        end
    end

    initial begin : mainSeq
        res = 1'b0;
        data = '0;
        dataValid = 1'b0;
        seed = 75;
        repeat (10) @(posedge clk);
        #2;
        res = 1'b1;
        fillStim(0);
        savedStim = stim;
        runFrame("clustered timestamps", 1'b0);
        fillStim(1);
        runFrame("window filtering", 1'b0);
        fillStim(2);
        runFrame("tie rule", 1'b0);
        fillStim(3);
        runFrame("saturation and forwarding", 1'b0);
        stim = savedStim;   // same data as the first frame
        runFrame("back-pressure", 1'b1);
        // abort a frame 100 samples into BUILD2
        fillStim(0);
        offerSamples(0, SMP + 100, 1'b0);
        res = 1'b0;
        @(negedge clk);
        checkFlag("wrEn", 1'b0, wrEn);
        checkFlag("resultValid", 1'b0, resultValid);
        repeat (3) @(posedge clk);
        #2;
        res = 1'b1;
        @(negedge clk);
        checkFlag("wrEn", 1'b0, wrEn);
        checkFlag("resultValid", 1'b0, resultValid);
        @(posedge clk);
        #2;
        runFrame("mid-frame reset", 1'b0);
        $display("%0d tests, %0d ok, %0d with mismatches, %0d errors", NUM_TESTS, testsOk,
                 NUM_TESTS - testsOk, errCnt);
        if (errCnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: frames did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/sifhPkg.sv
design/histRam.sv
design/hisBuilderFSM.sv
design/peakFinder.sv
design/SiFHtop.sv
sim/sifhTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    -f tb.f --top-module sifhTb -o sifhSim

./obj_dir/sifhSim > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log
